//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f spu_permute.f --top-module tb_spu_permute -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_spu_permute 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

//--- logic/forward_chain.sv
`timescale 1ns/1ns

module forward_chain
    import spu_isa_pkg::*;
    import spu_pipe_pkg::*;
(
    input  logic                             clock,
    input  logic                             reset,
    input  perm_cmd_t                        cmd,
    input  logic [0:QUAD_BITS-1]             shifted,
    input  logic [0:QUAD_BITS-1]             gathered,
    output fwd_entry_t [1:FWD_STAGES]        fwd
);

    fwd_entry_t                stage1;
    fwd_entry_t [2:FWD_STAGES] held;

    // stage 1 follows the issue register with no extra flop
    always_comb
    begin
        stage1 = '0;
        if (cmd.kind != KIND_NONE)
        begin
            stage1.unit_id  = PERMUTE_UNIT_ID;
            stage1.wrt_en   = 1'b1;
            stage1.rt_addr  = cmd.rt_addr;
            stage1.latency  = PERMUTE_LATENCY;
            if (cmd.kind == KIND_GATHER)
                stage1.rt_value = gathered;
            else
                stage1.rt_value = shifted;
        end
    end

    // stages 2 to 7 move down one step per clock
    always_ff @(posedge clock)
    begin
        if (reset)
            held <= '0;
        else
            held <= {stage1, held[2:FWD_STAGES-1]};
    end

    assign fwd = {stage1, held};

endmodule

//--- logic/gather_bits.sv
`timescale 1ns/1ns

module gather_bits
    import spu_isa_pkg::*;
    import spu_pipe_pkg::*;
(
    input  perm_cmd_t            cmd,
    output logic [0:QUAD_BITS-1] gathered
);

    int elem_bits;
    int n_elem;

    always_comb
    begin
        case (cmd.grain)
            GRAIN_HALF:
            begin
                elem_bits = HALF_BITS;
                n_elem    = QUAD_BYTES / 2;
            end
            GRAIN_WORD:
            begin
                elem_bits = WORD_BITS;
                n_elem    = QUAD_BYTES / 4;
            end
            default:
            begin
                elem_bits = BYTE_BITS;
                n_elem    = QUAD_BYTES;
            end
        endcase
    end

    // lsb of element j lands right aligned in the preferred word, element 0 highest
    always_comb
    begin
        gathered = '0;
        for (int j = 0; j < QUAD_BYTES; j++)
        begin
            if (j < n_elem)
            begin
                gathered[WORD_BITS - n_elem + j] = cmd.ra[j * elem_bits + elem_bits - 1];
            end
        end
    end

endmodule

//--- logic/permute_issue.sv
`timescale 1ns/1ns

module permute_issue
    import spu_isa_pkg::*;
    import spu_pipe_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  permute_op_t              op,
    input  logic [0:QUAD_BITS-1]     ra,
    input  logic [0:QUAD_BITS-1]     rb,
    input  logic [0:IMM7_BITS-1]     i7,
    input  logic [0:REG_ADDR_BITS-1] rt_addr,
    output perm_cmd_t                cmd
);

    permute_op_t              op_q;
    logic [0:QUAD_BITS-1]     ra_q;
    logic [0:QUAD_BITS-1]     rb_q;
    logic [0:IMM7_BITS-1]     i7_q;
    logic [0:REG_ADDR_BITS-1] rt_addr_q;

    // candidate counts, all zero extended to the command width
    logic [0:COUNT_BITS-1] rb_bit_cnt;
    logic [0:COUNT_BITS-1] i7_bit_cnt;
    logic [0:COUNT_BITS-1] rb_byte_cnt;
    logic [0:COUNT_BITS-1] i7_byte_cnt;
    logic [0:COUNT_BITS-1] rb_rot_cnt;
    logic [0:COUNT_BITS-1] i7_rot_cnt;
    logic [0:COUNT_BITS-1] rb_bitcnt_bytes;

    perm_kind_t            kind;
    perm_grain_t           grain;
    logic [0:COUNT_BITS-1] count;

    // an empty slot after reset is a nop
    always_ff @(posedge clock)
    begin
        if (reset)
            op_q <= OP_NOP;
        else
            op_q <= op;
    end

    always_ff @(posedge clock)
    begin
        ra_q      <= ra;
        rb_q      <= rb;
        i7_q      <= i7;
        rt_addr_q <= rt_addr;
    end

    assign rb_bit_cnt      = COUNT_BITS'(rb_q[PREF_LSB-BIT_CNT_BITS+1 +: BIT_CNT_BITS]);
    assign i7_bit_cnt      = COUNT_BITS'(i7_q[IMM7_BITS-BIT_CNT_BITS +: BIT_CNT_BITS]);
    assign rb_byte_cnt     = rb_q[PREF_LSB-COUNT_BITS+1 +: COUNT_BITS];
    assign i7_byte_cnt     = i7_q[IMM7_BITS-COUNT_BITS +: COUNT_BITS];
    assign rb_rot_cnt      = COUNT_BITS'(rb_q[PREF_LSB-ROT_CNT_BITS+1 +: ROT_CNT_BITS]);
    assign i7_rot_cnt      = COUNT_BITS'(i7_q[IMM7_BITS-ROT_CNT_BITS +: ROT_CNT_BITS]);
    assign rb_bitcnt_bytes = rb_q[BITCNT_FIELD_MSB +: COUNT_BITS];

    always_comb
    begin
        case (op_q)
            OP_SHLQBI, OP_SHLQBII, OP_SHLQBY, OP_SHLQBYI, OP_SHLQBYBI: kind = KIND_SHIFT;
            OP_ROTQBI, OP_ROTQBII, OP_ROTQBY, OP_ROTQBYI, OP_ROTQBYBI: kind = KIND_ROTATE;
            OP_GBB, OP_GBH, OP_GB: kind = KIND_GATHER;
            default: kind = KIND_NONE;
        endcase

        case (op_q)
            OP_SHLQBI, OP_SHLQBII, OP_ROTQBI, OP_ROTQBII: grain = GRAIN_BIT;
            OP_GBH: grain = GRAIN_HALF;
            OP_GB: grain = GRAIN_WORD;
            default: grain = GRAIN_BYTE;
        endcase

        // gathers and nop carry no count
        case (op_q)
            OP_SHLQBI, OP_ROTQBI: count = rb_bit_cnt;
            OP_SHLQBII, OP_ROTQBII: count = i7_bit_cnt;
            OP_SHLQBY: count = rb_byte_cnt;
            OP_SHLQBYI: count = i7_byte_cnt;
            OP_ROTQBY: count = rb_rot_cnt;
            OP_ROTQBYI: count = i7_rot_cnt;
            OP_SHLQBYBI, OP_ROTQBYBI: count = rb_bitcnt_bytes;
            default: count = '0;
        endcase
    end

    assign cmd.kind    = kind;
    assign cmd.grain   = grain;
    assign cmd.count   = count;
    assign cmd.rt_addr = rt_addr_q;
    assign cmd.ra      = ra_q;

endmodule

//--- logic/quadword_shifter.sv
`timescale 1ns/1ns

module quadword_shifter
    import spu_isa_pkg::*;
    import spu_pipe_pkg::*;
(
    input  perm_cmd_t            cmd,
    output logic [0:QUAD_BITS-1] shifted
);

    logic is_rotate;
    int   amt;

    assign is_rotate = (cmd.kind == KIND_ROTATE);

    // total movement in bit positions
    always_comb
    begin
        if (cmd.grain == GRAIN_BIT)
        begin
            amt = int'(cmd.count);
        end
        else if (is_rotate)
        begin
            // the bit count form can hand over 5 bits, a rotate wraps at 16 bytes
            amt = (int'(cmd.count) % QUAD_BYTES) * BYTE_BITS;
        end
        else
        begin
            // 16 bytes or more pushes every source bit out
            amt = int'(cmd.count) * BYTE_BITS;
        end
    end

    // bit b takes source bit b+amt, moving data toward bit 0
    always_comb
    begin
        int src;
        src = 0;
        for (int b = 0; b < QUAD_BITS; b++)
        begin
            src = b + amt;
            if (src < QUAD_BITS)
            begin
                shifted[b] = cmd.ra[src];
            end
            else if (is_rotate)
            begin
                shifted[b] = cmd.ra[src - QUAD_BITS];
            end
            else
            begin
                // zero fill at the low end
                shifted[b] = 1'b0;
            end
        end
    end

endmodule

//--- logic/spu_isa_pkg.sv
package spu_isa_pkg;

    // operand and element widths
    localparam int QUAD_BITS     = 128;
    localparam int QUAD_BYTES    = 16;
    localparam int BYTE_BITS     = 8;
    localparam int HALF_BITS     = 16;
    localparam int WORD_BITS     = 32;
    localparam int IMM7_BITS     = 7;
    localparam int REG_ADDR_BITS = 7;

    // shift count fields, bit 0 is the msb of the preferred word
    localparam int COUNT_BITS       = 5;
    localparam int BIT_CNT_BITS     = 3;
    localparam int ROT_CNT_BITS     = 4;
    localparam int PREF_LSB         = WORD_BITS - 1;
    // byte count taken from a bit count sits in bits 24 to 28
    localparam int BITCNT_FIELD_MSB = 24;

    typedef enum logic [4:0] {
        OP_SHLQBI,
        OP_SHLQBII,
        OP_SHLQBY,
        OP_SHLQBYI,
        OP_SHLQBYBI,
        OP_ROTQBY,
        OP_ROTQBYI,
        OP_ROTQBYBI,
        OP_ROTQBI,
        OP_ROTQBII,
        OP_GBB,
        OP_GBH,
        OP_GB,
        OP_NOP
    } permute_op_t;

    typedef enum logic [1:0] {
        KIND_SHIFT,
        KIND_ROTATE,
        KIND_GATHER,
        KIND_NONE
    } perm_kind_t;

    typedef enum logic [1:0] {
        GRAIN_BIT,
        GRAIN_BYTE,
        GRAIN_HALF,
        GRAIN_WORD
    } perm_grain_t;

endpackage

//--- logic/spu_permute.sv
`timescale 1ns/1ns

module spu_permute
    import spu_isa_pkg::*;
    import spu_pipe_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  permute_op_t               op,
    input  logic [0:QUAD_BITS-1]      ra,
    input  logic [0:QUAD_BITS-1]      rb,
    input  logic [0:IMM7_BITS-1]      i7,
    input  logic [0:REG_ADDR_BITS-1]  rt_addr,
    output fwd_entry_t [1:FWD_STAGES] fwd
);

    perm_cmd_t            cmd;
    logic [0:QUAD_BITS-1] shifted;
    logic [0:QUAD_BITS-1] gathered;

    permute_issue u_issue (
        .clock   (clock),
        .reset   (reset),
        .op      (op),
        .ra      (ra),
        .rb      (rb),
        .i7      (i7),
        .rt_addr (rt_addr),
        .cmd     (cmd)
    );

    quadword_shifter u_shifter (
        .cmd     (cmd),
        .shifted (shifted)
    );

    gather_bits u_gather (
        .cmd      (cmd),
        .gathered (gathered)
    );

    // result select and the seven visible stages
    forward_chain u_chain (
        .clock    (clock),
        .reset    (reset),
        .cmd      (cmd),
        .shifted  (shifted),
        .gathered (gathered),
        .fwd      (fwd)
    );

endmodule

//--- logic/spu_pipe_pkg.sv
package spu_pipe_pkg;

    import spu_isa_pkg::*;

    localparam int FWD_STAGES   = 7;
    localparam int UNIT_ID_BITS = 3;
    localparam int LATENCY_BITS = 4;

    // identity of the permute unit on the bypass network
    localparam logic [0:UNIT_ID_BITS-1] PERMUTE_UNIT_ID = 3'd5;
    localparam logic [0:LATENCY_BITS-1] PERMUTE_LATENCY = 4'd4;

    // one forwarding stage, 143 bits
    typedef struct packed {
        logic [0:UNIT_ID_BITS-1]  unit_id;
        logic [0:QUAD_BITS-1]     rt_value;
        logic                     wrt_en;
        logic [0:REG_ADDR_BITS-1] rt_addr;
        logic [0:LATENCY_BITS-1]  latency;
    } fwd_entry_t;

    // decoded instruction handed to the datapath
    typedef struct packed {
        perm_kind_t               kind;
        perm_grain_t              grain;
        logic [0:COUNT_BITS-1]    count;
        logic [0:REG_ADDR_BITS-1] rt_addr;
        logic [0:QUAD_BITS-1]     ra;
    } perm_cmd_t;

endpackage

//--- spu_permute.f
+incdir+verif
logic/spu_isa_pkg.sv
logic/spu_pipe_pkg.sv
logic/permute_issue.sv
logic/quadword_shifter.sv
logic/gather_bits.sv
logic/forward_chain.sv
logic/spu_permute.sv
verif/tb_spu_permute.sv

//--- verif/tb_permute_model.svh
`ifndef TB_PERMUTE_MODEL_SVH
`define TB_PERMUTE_MODEL_SVH

// model result classes
localparam int MODE_SHIFT  = 0;
localparam int MODE_ROTATE = 1;
localparam int MODE_GATHER = 2;
localparam int MODE_NONE   = 3;

// one shared stream for all stimulus
logic [31:0] lcg_state = 32'h5c18_d6b6;

function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic [0:QUAD_BITS-1] random_quad();
    logic [0:QUAD_BITS-1] q;
    q = '0;
    for (int w = 0; w < 4; w++)
    begin
        q = {q[32:QUAD_BITS-1], next_random()};
    end
    return q;
endfunction

// expected forwarding entry for one instruction, worked out from the ISA rules
function automatic fwd_entry_t model_entry(
    input permute_op_t                op_m,
    input logic [0:QUAD_BITS-1]       ra_m,
    input logic [0:QUAD_BITS-1]       rb_m,
    input logic [0:IMM7_BITS-1]       i7_m,
    input logic [0:REG_ADDR_BITS-1]   rt_m
);
    logic [127:0] src;
    logic [127:0] value;
    logic [31:0]  pref;
    logic [6:0]   imm;
    logic [31:0]  packed_bits;
    int           amt;
    int           elem;
    int           mode;
    fwd_entry_t   e;

    // numeric view, msb of the quadword is bit 0 of the operand
    src         = ra_m;
    pref        = rb_m[0:31];
    imm         = i7_m;
    amt         = 0;
    elem        = 8;
    mode        = MODE_NONE;
    packed_bits = '0;
    value       = '0;

    case (op_m)
        OP_SHLQBI:
        begin
            mode = MODE_SHIFT;
            amt  = int'(pref[2:0]);
        end
        OP_SHLQBII:
        begin
            mode = MODE_SHIFT;
            amt  = int'(imm[2:0]);
        end
        OP_SHLQBY:
        begin
            mode = MODE_SHIFT;
            amt  = int'(pref[4:0]) * 8;
        end
        OP_SHLQBYI:
        begin
            mode = MODE_SHIFT;
            amt  = int'(imm[4:0]) * 8;
        end
        OP_SHLQBYBI:
        begin
            // bit count divided by 8
            mode = MODE_SHIFT;
            amt  = int'(pref[7:3]) * 8;
        end
        OP_ROTQBY:
        begin
            mode = MODE_ROTATE;
            amt  = int'(pref[3:0]) * 8;
        end
        OP_ROTQBYI:
        begin
            mode = MODE_ROTATE;
            amt  = int'(imm[3:0]) * 8;
        end
        OP_ROTQBYBI:
        begin
            mode = MODE_ROTATE;
            amt  = int'(pref[7:3]) * 8;
        end
        OP_ROTQBI:
        begin
            mode = MODE_ROTATE;
            amt  = int'(pref[2:0]);
        end
        OP_ROTQBII:
        begin
            mode = MODE_ROTATE;
            amt  = int'(imm[2:0]);
        end
        OP_GBB:
        begin
            mode = MODE_GATHER;
            elem = 8;
        end
        OP_GBH:
        begin
            mode = MODE_GATHER;
            elem = 16;
        end
        OP_GB:
        begin
            mode = MODE_GATHER;
            elem = 32;
        end
        default:
        begin
            mode = MODE_NONE;
        end
    endcase

    if (mode == MODE_SHIFT)
    begin
        if (amt >= QUAD_BITS)
            value = '0;
        else
            value = src << amt;
    end
    else if (mode == MODE_ROTATE)
    begin
        // a full turn of 16 bytes leaves the operand unchanged
        amt = amt % QUAD_BITS;
        if (amt == 0)
            value = src;
        else
            value = (src << amt) | (src >> (QUAD_BITS - amt));
    end
    else if (mode == MODE_GATHER)
    begin
        for (int j = 0; j < QUAD_BITS / elem; j++)
        begin
            packed_bits = (packed_bits << 1) | 32'(src[QUAD_BITS - (j + 1) * elem]);
        end
        value = {packed_bits, {(QUAD_BITS - 32){1'b0}}};
    end

    e = '0;
    if (mode != MODE_NONE)
    begin
        e.unit_id  = 3'd5;
        e.rt_value = value;
        e.wrt_en   = 1'b1;
        e.rt_addr  = rt_m;
        e.latency  = 4'd4;
    end
    return e;
endfunction

`endif

//--- verif/tb_spu_permute.sv
`timescale 1ns/1ns

module tb_spu_permute
    import spu_isa_pkg::*;
    import spu_pipe_pkg::*;
();

    localparam int CLOCK_PERIOD    = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int POST_RESET_NOPS = 4;
    localparam int N_SHIFT         = 300;
    localparam int N_ROTATE        = 300;
    localparam int N_GATHER        = 200;
    localparam int N_MIXED         = 400;
    localparam int DRAIN           = FWD_STAGES + 1;
    localparam int TOTAL_INSTR     = POST_RESET_NOPS + N_SHIFT + N_ROTATE + N_GATHER
                                     + N_MIXED + DRAIN;
    localparam int WATCHDOG_NS     = (TOTAL_INSTR + RESET_CYCLES + 20) * CLOCK_PERIOD;

    localparam int GROUP_SHIFT  = 0;
    localparam int GROUP_ROTATE = 1;
    localparam int GROUP_GATHER = 2;
    localparam int GROUP_MIXED  = 3;

    localparam permute_op_t SHIFT_OPS [5] = '{OP_SHLQBI, OP_SHLQBII, OP_SHLQBY,
                                              OP_SHLQBYI, OP_SHLQBYBI};
    localparam permute_op_t ROTATE_OPS [5] = '{OP_ROTQBY, OP_ROTQBYI, OP_ROTQBYBI,
                                               OP_ROTQBI, OP_ROTQBII};
    localparam permute_op_t GATHER_OPS [3] = '{OP_GBB, OP_GBH, OP_GB};

    logic                      clock;
    logic                      reset;
    permute_op_t               op;
    logic [0:QUAD_BITS-1]      ra;
    logic [0:QUAD_BITS-1]      rb;
    logic [0:IMM7_BITS-1]      i7;
    logic [0:REG_ADDR_BITS-1]  rt_addr;
    fwd_entry_t [1:FWD_STAGES] fwd;

    // expected contents of every stage
    fwd_entry_t hist [1:FWD_STAGES];
    string      test_name;

    `include "tb_permute_model.svh"

    spu_permute uut (
        .clock   (clock),
        .reset   (reset),
        .op      (op),
        .ra      (ra),
        .rb      (rb),
        .i7      (i7),
        .rt_addr (rt_addr),
        .fwd     (fwd)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic check_value(input string name, input fwd_entry_t expected,
                               input fwd_entry_t actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic check_stages();
        for (int k = 1; k <= FWD_STAGES; k++)
        begin
            check_value($sformatf("%s stage %0d", test_name, k), hist[k], fwd[k]);
        end
    endtask

    // outputs are checked before each new instruction goes out on the falling edge
    task automatic issue_instr(input permute_op_t next_op, input logic [0:QUAD_BITS-1] next_ra,
                               input logic [0:QUAD_BITS-1] next_rb,
                               input logic [0:IMM7_BITS-1] next_i7,
                               input logic [0:REG_ADDR_BITS-1] next_rt);
        @(negedge clock);
        check_stages();
        op      = next_op;
        ra      = next_ra;
        rb      = next_rb;
        i7      = next_i7;
        rt_addr = next_rt;
        // the coming rising edge moves each entry one stage down
        for (int k = FWD_STAGES; k > 1; k--)
        begin
            hist[k] = hist[k - 1];
        end
        hist[1] = model_entry(next_op, next_ra, next_rb, next_i7, next_rt);
    endtask

    function automatic permute_op_t random_op(input int group);
        logic [31:0] r;
        int          pick;
        permute_op_t result;
        r    = next_random();
        pick = int'(r[31:16]);
        case (group)
            GROUP_SHIFT:  result = SHIFT_OPS[pick % 5];
            GROUP_ROTATE: result = ROTATE_OPS[pick % 5];
            GROUP_GATHER: result = GATHER_OPS[pick % 3];
            default:
            begin
                // about one slot in four of mixed traffic stays idle
                case (pick % 4)
                    0:       result = SHIFT_OPS[(pick / 4) % 5];
                    1:       result = ROTATE_OPS[(pick / 4) % 5];
                    2:       result = GATHER_OPS[(pick / 4) % 3];
                    default: result = OP_NOP;
                endcase
            end
        endcase
        return result;
    endfunction

    task automatic issue_random(input int group);
        permute_op_t              next_op;
        logic [0:QUAD_BITS-1]     next_ra;
        logic [0:QUAD_BITS-1]     next_rb;
        logic [31:0]              r;
        next_op = random_op(group);
        next_ra = random_quad();
        next_rb = random_quad();
        r       = next_random();
        issue_instr(next_op, next_ra, next_rb, r[22:16], r[30:24]);
    endtask

    initial
    begin
        test_name   = "reset";
        clock       = 1'b0;
        reset       = 1'b1;
        op          = OP_NOP;
        ra          = '0;
        rb          = '0;
        i7          = '0;
        rt_addr     = '0;
        for (int k = 1; k <= FWD_STAGES; k++)
        begin
            hist[k] = '0;
        end

        repeat (RESET_CYCLES)
        begin
            @(negedge clock);
            check_stages();
        end
        reset = 1'b0;

        test_name = "after reset";
        repeat (POST_RESET_NOPS) issue_instr(OP_NOP, '0, '0, '0, '0);

        test_name = "shift";
        repeat (N_SHIFT) issue_random(GROUP_SHIFT);

        test_name = "rotate";
        repeat (N_ROTATE) issue_random(GROUP_ROTATE);

        test_name = "gather";
        repeat (N_GATHER) issue_random(GROUP_GATHER);

        test_name = "mixed";
        repeat (N_MIXED) issue_random(GROUP_MIXED);

        // let the last instructions walk through all seven stages
        test_name = "drain";
        repeat (DRAIN) issue_instr(OP_NOP, '0, '0, '0, '0);
        @(negedge clock);
        check_stages();

        $display("all tests passed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("the run did not finish within the time limit");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule
